// ==== uart_min.f ====
source/uart_pkg.sv
source/byte_fifo_if.sv
source/us_tick_gen.sv
source/byte_fifo.sv
source/uart_rx_deframer.sv
source/uart_tx_framer.sv
source/uart_wb_regs.sv
source/uart_min_top.sv
verification/uart_min_chk.sv
verification/uart_min_tb.sv

// ==== Makefile ====
# Verilator build and run of the minimal UART testbench

TOP := uart_min_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f uart_min.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== verification/uart_min_tb.sv ====
//----------------------------------------------------------------------
// Testbench for the minimal UART with Wishbone and serial drivers,
// a queue reference model of both FIFOs and a scoreboard
//----------------------------------------------------------------------

`timescale 1ns/100ps

module uart_min_tb
   import uart_pkg::*;
();

   // One bit is 86.8 clocks of 100 ns
   localparam int BIT_CLKS   = 87;
   localparam int HALF_CLKS  = 43;
   localparam int ACK_LIMIT  = 20;
   localparam int EDGE_LIMIT = 3000;
   localparam int POLL_LIMIT = 200;
   localparam int FIFO_DEPTH = 16;

   logic     clk;
   logic     arst_n;
   logic     uart_rx;
   logic     uart_tx;
   logic     wb_cyc;
   logic     wb_stb;
   logic     wb_we;
   wb_adr_t  wb_adr;
   wb_data_t wb_dat_w;
   wb_data_t wb_dat_r;
   logic     wb_ack;

   // Reference model of the rx FIFO, tx FIFO and overflow flag
   byte_t    rx_model[$];
   byte_t    tx_expect[$];
   int       tx_level;
   bit       oflow_model;

   // Results waiting for the comparator
   string    what_q[$];
   wb_data_t got_q[$];
   wb_data_t exp_q[$];

   int       err_cnt;
   int       timeout_cnt;
   integer   seed;

   uart_min_top #(.CLKS_PER_US(10), .FIFO_AW(4)) dut_i (
      .clk(clk), .arst_n(arst_n), .uart_rx(uart_rx), .uart_tx(uart_tx),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //-------------------------------------------------------------------
   // Reference model and result checking
   //-------------------------------------------------------------------
   // Expected read value from the model state before the access
   function automatic wb_data_t ref_read(wb_adr_t adr);
      wb_data_t val;
      val = '0;
      if (adr == REG_DATA && rx_model.size() > 0) begin
         val[7:0] = rx_model[0];
      end
      else if (adr == REG_STATUS) begin
         val[STAT_RX_VALID] = (rx_model.size() > 0);
         val[STAT_RX_OFLOW] = oflow_model;
         val[STAT_TX_BUSY]  = (tx_level == FIFO_DEPTH);
      end
      return val;
   endfunction

   task automatic post_result(string what, wb_data_t got, wb_data_t exp);
      what_q.push_back(what);
      got_q.push_back(got);
      exp_q.push_back(exp);
   endtask

   task automatic check_value(string what, wb_data_t got, wb_data_t exp);
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Comparator draining the result queues every clock
   initial begin
      string    what;
      wb_data_t got;
      wb_data_t exp;
      forever begin
         @(posedge clk);
         while (got_q.size() > 0) begin
            what = what_q.pop_front();
            got  = got_q.pop_front();
            exp  = exp_q.pop_front();
            check_value(what, got, exp);
         end
      end
   end

   //-------------------------------------------------------------------
   // Wishbone master
   //-------------------------------------------------------------------
   task automatic wb_write(wb_adr_t adr, wb_data_t data);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = data;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < ACK_LIMIT);
      if (!wb_ack) begin
         timeout_cnt++;
         $display("Timeout: no Wishbone ack for the write to register %0d", adr);
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(wb_adr_t adr, output wb_data_t data);
      int waited;
      waited = 0;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < ACK_LIMIT);
      if (!wb_ack) begin
         timeout_cnt++;
         $display("Timeout: no Wishbone ack for the read of register %0d", adr);
      end
      data   = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   // Checked read followed by the model update for its side effect
   task automatic read_and_check(string what, wb_adr_t adr);
      wb_data_t exp;
      wb_data_t got;
      exp = ref_read(adr);
      wb_read(adr, got);
      post_result(what, got, exp);
      if (adr == REG_DATA) begin
         if (rx_model.size() > 0) begin
            void'(rx_model.pop_front());
         end
         oflow_model = 1'b0;
      end
   endtask

   // Write to DATA that the DUT drops when the tx FIFO is full
   task automatic write_data(byte_t data);
      wb_write(REG_DATA, wb_data_t'(data));
      if (tx_level < FIFO_DEPTH) begin
         tx_level++;
         tx_expect.push_back(data);
      end
   endtask

   // Poll STATUS until a received byte is reported
   task automatic wait_rx_valid();
      wb_data_t stat;
      int       polls;
      stat  = '0;
      polls = 0;
      while (!stat[STAT_RX_VALID] && polls < POLL_LIMIT) begin
         wb_read(REG_STATUS, stat);
         polls++;
      end
      if (!stat[STAT_RX_VALID]) begin
         timeout_cnt++;
         $display("Timeout: rx valid never showed in STATUS");
      end
   endtask

   //-------------------------------------------------------------------
   // Serial side
   //-------------------------------------------------------------------
   // Start bit, data LSB first, stop bit
   task automatic send_serial(byte_t data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         uart_rx = frame[i];
         repeat (BIT_CLKS) @(negedge clk);
      end
      // Stop sample is long done so the byte is in or dropped
      if (rx_model.size() < FIFO_DEPTH) begin
         rx_model.push_back(data);
      end
      else begin
         oflow_model = 1'b1;
      end
   endtask

   task automatic capture_frame(output byte_t data, output bit seen);
      logic prev;
      int   waited;
      prev   = uart_tx;
      waited = 0;
      seen   = 1'b0;
      data   = '0;
      while (!seen && waited < EDGE_LIMIT) begin
         @(negedge clk);
         waited++;
         seen = prev & ~uart_tx;
         prev = uart_tx;
      end
      if (!seen) begin
         timeout_cnt++;
         $display("Timeout: no start edge on uart_tx");
      end
      else begin
         // Middle of the start bit and then one bit period per sample
         repeat (HALF_CLKS) @(negedge clk);
         post_result("tx start bit", wb_data_t'(uart_tx), 0);
         for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            data[i] = uart_tx;
         end
         repeat (BIT_CLKS) @(negedge clk);
         post_result("tx stop bit", wb_data_t'(uart_tx), 1);
      end
   endtask

   task automatic watch_tx_frames(int count);
      byte_t data;
      bit    seen;
      for (int k = 0; k < count; k++) begin
         capture_frame(data, seen);
         if (seen) begin
            if (tx_expect.size() == 0) begin
               err_cnt++;
               $display("Frame on uart_tx with data %h that was never written", data);
            end
            else begin
               post_result("tx frame", wb_data_t'(data), wb_data_t'(tx_expect.pop_front()));
               tx_level--;
            end
         end
      end
   endtask

   //-------------------------------------------------------------------
   // Test sequence
   //-------------------------------------------------------------------
   initial begin
      byte_t data;
      int    total;
      seed        = 67;
      err_cnt     = 0;
      timeout_cnt = 0;
      tx_level    = 0;
      oflow_model = 1'b0;
      arst_n      = 1'b0;
      uart_rx     = 1'b1;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);

      // Idle state out of reset
      post_result("uart_tx after reset", wb_data_t'(uart_tx), 1);
      read_and_check("status after reset", REG_STATUS);
      read_and_check("data with rx empty", REG_DATA);
      read_and_check("unmapped register", 2'd3);

      // Single byte out
      data = byte_t'($random(seed));
      fork
         write_data(data);
         watch_tx_frames(1);
      join
      // Pop comes after the stop bit ends
      repeat (100) @(negedge clk);

      // Sixteen bytes back to back fill the tx FIFO
      fork
         begin
            for (int i = 0; i < FIFO_DEPTH; i++) begin
               data = byte_t'($random(seed));
               write_data(data);
            end
            read_and_check("status with tx full", REG_STATUS);
         end
         watch_tx_frames(FIFO_DEPTH);
      join
      repeat (100) @(negedge clk);
      read_and_check("status after tx burst", REG_STATUS);

      // Single byte in
      data = byte_t'($random(seed));
      send_serial(data);
      wait_rx_valid();
      read_and_check("status with one rx byte", REG_STATUS);
      read_and_check("rx data", REG_DATA);
      read_and_check("status after rx read", REG_STATUS);

      // Seventeen bytes in and the last one overflows
      for (int i = 0; i <= FIFO_DEPTH; i++) begin
         data = byte_t'($random(seed));
         send_serial(data);
      end
      repeat (20) @(negedge clk);
      read_and_check("status after rx overflow", REG_STATUS);
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         read_and_check("rx data in order", REG_DATA);
         if (i == 0) begin
            read_and_check("status after first read", REG_STATUS);
         end
      end
      read_and_check("status with rx drained", REG_STATUS);

      // Let the comparator drain
      repeat (2) @(negedge clk);
      total = err_cnt + timeout_cnt + dut_i.chk_i.assert_fails;
      $display("Errors: %0d wrong values, %0d timeouts, %0d assertion failures",
               err_cnt, timeout_cnt, dut_i.chk_i.assert_fails);
      if (total == 0) begin
         $display("All checks passed");
      end
      else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== verification/uart_min_chk.sv ====
//----------------------------------------------------------------------
// Bound checks on the Wishbone handshake and the idle serial line
//----------------------------------------------------------------------

`timescale 1ns/100ps

module uart_min_chk (
   input logic clk,
   input logic arst_n,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic uart_tx
);

   // Count of failed assertions
   int assert_fails = 0;

   // Ack only answers a request that was live on the edge that raised it
   ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
      else begin
         $error("wb_ack rose without cyc and stb");
         assert_fails++;
      end

   // Single-cycle ack
   ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else begin
         $error("wb_ack held high for two cycles");
         assert_fails++;
      end

   // Line idles high out of reset
   tx_idle_high: assert property (@(posedge clk) !arst_n |=> uart_tx)
      else begin
         $error("uart_tx low in the cycle after reset");
         assert_fails++;
      end

endmodule

bind uart_min_top uart_min_chk chk_i (
   .clk(clk), .arst_n(arst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
   .wb_ack(wb_ack), .uart_tx(uart_tx)
);

// ==== source/uart_min_top.sv ====
//----------------------------------------------------------------------
// Minimal UART, 115.2 kbit/s 8N1, 16-byte FIFO per direction,
// Wishbone classic register port
//----------------------------------------------------------------------

`timescale 1ns/100ps

module uart_min_top
   import uart_pkg::*;
#(
   parameter int unsigned CLKS_PER_US = 10,
   parameter int unsigned FIFO_AW     = 4
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     uart_rx,
   output logic     uart_tx,
   input  logic     wb_cyc,
   input  logic     wb_stb,
   input  logic     wb_we,
   input  wb_adr_t  wb_adr,
   input  wb_data_t wb_dat_w,
   output wb_data_t wb_dat_r,
   output logic     wb_ack
);

   logic tick;
   logic oflow_set;

   // Rx: deframer to register port, Tx: register port to framer
   byte_fifo_if rx_q ();
   byte_fifo_if tx_q ();

   // Shared microsecond time base
   us_tick_gen #(.CLKS_PER_US(CLKS_PER_US)) tick_i (
      .clk(clk), .arst_n(arst_n), .tick(tick)
   );

   //------------------------------------------------------------------
   // Receive path
   //------------------------------------------------------------------
   uart_rx_deframer rx_i (
      .clk(clk), .arst_n(arst_n), .tick(tick), .uart_rx(uart_rx),
      .q(rx_q.writer), .oflow_set(oflow_set)
   );

   byte_fifo #(.FIFO_AW(FIFO_AW)) rx_fifo_i (.clk(clk), .arst_n(arst_n), .q(rx_q.fifo));

   //------------------------------------------------------------------
   // Transmit path
   //------------------------------------------------------------------
   byte_fifo #(.FIFO_AW(FIFO_AW)) tx_fifo_i (.clk(clk), .arst_n(arst_n), .q(tx_q.fifo));

   uart_tx_framer tx_i (
      .clk(clk), .arst_n(arst_n), .tick(tick), .q(tx_q.reader), .uart_tx(uart_tx)
   );

   // CPU side
   uart_wb_regs regs_i (
      .clk(clk), .arst_n(arst_n),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .oflow_set(oflow_set), .rx_q(rx_q.reader), .tx_q(tx_q.writer)
   );

endmodule

// ==== source/uart_wb_regs.sv ====
//----------------------------------------------------------------------
// Wishbone classic slave with DATA and STATUS registers and the
// sticky rx overflow flag
//----------------------------------------------------------------------

`timescale 1ns/100ps

module uart_wb_regs
   import uart_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         wb_cyc,
   input  logic         wb_stb,
   input  logic         wb_we,
   input  wb_adr_t      wb_adr,
   input  wb_data_t     wb_dat_w,
   output wb_data_t     wb_dat_r,
   output logic         wb_ack,
   input  logic         oflow_set,
   byte_fifo_if.reader  rx_q,
   byte_fifo_if.writer  tx_q
);

   logic     access;
   logic     data_rd;
   logic     rx_oflow;
   wb_data_t status;
   wb_data_t rd_val;

   always_comb begin
      // New cycle seen, ack goes out on the next edge
      access  = wb_cyc & wb_stb & ~wb_ack;
      data_rd = access & ~wb_we & (wb_adr == REG_DATA);

      // Tx push, dropped inside the FIFO when full
      tx_q.wdata = wb_dat_w[7:0];
      tx_q.push  = access & wb_we & (wb_adr == REG_DATA);
      rx_q.pop   = data_rd;

      status                = '0;
      status[STAT_RX_VALID] = ~rx_q.empty;
      status[STAT_RX_OFLOW] = rx_oflow;
      status[STAT_TX_BUSY]  = tx_q.full;

      // Read mux, unmapped addresses read 0
      case (wb_adr)
         REG_DATA:   rd_val = rx_q.empty ? '0 : wb_data_t'(rx_q.rdata);
         REG_STATUS: rd_val = status;
         default:    rd_val = '0;
      endcase
   end

   //------------------------------------------------------------------
   // Handshake and overflow flag
   //------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         wb_ack   <= 1'b0;
         rx_oflow <= 1'b0;
      end
      else begin
         wb_ack <= access;
         // Set from the receiver wins over the clear by a DATA read
         if (oflow_set) begin
            rx_oflow <= 1'b1;
         end
         else if (data_rd) begin
            rx_oflow <= 1'b0;
         end
      end
   end

   // Read data is captured with the ack
   always_ff @(posedge clk) begin
      if (access) begin
         wb_dat_r <= wb_we ? '0 : rd_val;
      end
   end

endmodule

// ==== source/uart_tx_framer.sv ====
//----------------------------------------------------------------------
// UART transmitter: start bit, 8 data bits LSB first and stop bit,
// edges placed on the microsecond tick
//----------------------------------------------------------------------

`timescale 1ns/100ps

module uart_tx_framer
   import uart_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         tick,
   byte_fifo_if.reader  q,
   output logic         uart_tx
);

   uart_bit_state_t tx_state;
   uart_bit_state_t tx_next;
   us_cnt_t         tx_cnt;
   logic            tx_nextbit;

   //------------------------------------------------------------------
   // Edge placement
   //------------------------------------------------------------------
   // Ideal edges sit at multiples of 8.68 us from the start edge.
   // Bits last 9, 8, 9, 9, 8, 9, 9, 8, 9 us from START to D7,
   // which keeps every edge within 0.44 us of its ideal place.
   // STOP lasts 9 us and the next frame waits for the next tick

   always_comb begin
      tx_nextbit = tick & (tx_cnt == '0);
      tx_next    = uart_bit_state_t'(4'(tx_state) + 4'd1);
      // Byte leaves the FIFO head once the stop bit is done
      q.pop      = tx_nextbit & (tx_state == STOP);
   end

   //------------------------------------------------------------------
   // Bit state machine
   //------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         tx_state <= IDLE;
         tx_cnt   <= '0;
         uart_tx  <= 1'b1;
      end
      else begin
         if (tick && (tx_state != IDLE)) begin
            tx_cnt <= tx_cnt - us_cnt_t'(1);
         end

         case (tx_state)
            // Line idles high, start as soon as a byte is queued
            IDLE: begin
               uart_tx <= 1'b1;
               tx_cnt  <= TX_WAIT[0];
               if (!q.empty) begin
                  tx_state <= START;
               end
            end

            // First tick drops the line, aligning the frame to the tick
            START: begin
               if (tick) begin
                  uart_tx <= 1'b0;
                  if (tx_cnt == '0) begin
                     uart_tx  <= q.rdata[0];
                     tx_cnt   <= TX_WAIT[1];
                     tx_state <= D0;
                  end
               end
            end

            // Line already high
            STOP: begin
               if (tx_nextbit) begin
                  tx_state <= IDLE;
               end
            end

            // D0..D7, drive the next data bit or the stop level
            default: begin
               if (tx_nextbit) begin
                  uart_tx  <= (tx_next == STOP) ? 1'b1 : q.rdata[tx_next[2:0]];
                  tx_cnt   <= TX_WAIT[4'(tx_next) + 4'd1];
                  tx_state <= tx_next;
               end
            end
         endcase
      end
   end

endmodule

// ==== source/uart_rx_deframer.sv ====
//----------------------------------------------------------------------
// UART receiver: start detection, bit sampling near the bit centre
// on the microsecond tick, byte assembly and push into the rx FIFO
//----------------------------------------------------------------------

`timescale 1ns/100ps

module uart_rx_deframer
   import uart_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         tick,
   input  logic         uart_rx,
   byte_fifo_if.writer  q,
   output logic         oflow_set
);

   uart_bit_state_t rx_state;
   uart_bit_state_t rx_next;
   us_cnt_t         rx_cnt;
   logic            rx_nextbit;
   logic            rx_is_data;
   logic            rx_done;
   byte_t           rx_shift;

   //------------------------------------------------------------------
   // Sample point placement
   //------------------------------------------------------------------
   // Bit period is 8.68 us and the tick is free-running, so each wait
   // lands somewhere in a one microsecond window:
   //   D0 at 13..14 us after the start edge, ideal 13.02
   //   then 8 or 9 us per bit, alternating to follow the ideal centres
   //   STOP at 82..83 us, ideal 82.46
   // Worst error stays under 1 us of a 4.34 us half bit

   always_comb begin
      rx_nextbit = tick & (rx_cnt == '0);
      // D0..STOP are consecutive codes
      rx_next    = uart_bit_state_t'(4'(rx_state) + 4'd1);
      rx_is_data = (4'(rx_state) < 4'(STOP));
      rx_done    = rx_nextbit & (rx_state == STOP);

      q.wdata    = rx_shift;
      // FIFO drops the byte itself when full
      q.push     = rx_done;
      oflow_set  = rx_done & q.full;
   end

   //------------------------------------------------------------------
   // Bit state machine
   //------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         rx_state <= IDLE;
         rx_cnt   <= '0;
      end
      else begin
         // Count ticks down while a frame is in progress
         if (tick && (rx_state != IDLE)) begin
            rx_cnt <= rx_cnt - us_cnt_t'(1);
         end

         case (rx_state)
            // Start bit is never sampled, the D0 wait covers it
            IDLE: begin
               rx_cnt <= RX_WAIT[0];
               if (!uart_rx) begin
                  rx_state <= D0;
               end
            end

            // Byte is handed over on this expiry
            STOP: begin
               if (rx_nextbit) begin
                  rx_state <= IDLE;
               end
            end

            // D0..D7, move on and reload the next wait
            default: begin
               if (rx_nextbit) begin
                  rx_cnt   <= RX_WAIT[rx_next];
                  rx_state <= rx_next;
               end
            end
         endcase
      end
   end

   // Shift register, LSB arrives first so bits enter at the MSB end
   always_ff @(posedge clk) begin
      if (rx_nextbit && rx_is_data) begin
         rx_shift <= {uart_rx, rx_shift[7:1]};
      end
   end

endmodule

// ==== source/byte_fifo.sv ====
//----------------------------------------------------------------------
// Synchronous fall-through byte FIFO with full and empty flags
//----------------------------------------------------------------------

`timescale 1ns/100ps

module byte_fifo
   import uart_pkg::*;
#(
   parameter int unsigned FIFO_AW = 4
) (
   input  logic       clk,
   input  logic       arst_n,
   byte_fifo_if.fifo  q
);

   localparam int unsigned DEPTH = 2 ** FIFO_AW;

   byte_t              mem [DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   // One bit wider than the pointers to tell full from empty
   logic [FIFO_AW:0]   count;
   logic               do_push;
   logic               do_pop;

   always_comb begin
      q.full  = (count == (FIFO_AW+1)'(DEPTH));
      q.empty = (count == '0);
      // Overflow and underflow requests are dropped here
      do_push = q.push & ~q.full;
      do_pop  = q.pop & ~q.empty;
      // Head entry, visible without a pop
      q.rdata = mem[rd_ptr];
   end

   // Storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= q.wdata;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Push and pop together leave the count as is
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== source/us_tick_gen.sv ====
//----------------------------------------------------------------------
// Microsecond time base, one-clock tick every CLKS_PER_US clocks
//----------------------------------------------------------------------

`timescale 1ns/100ps

module us_tick_gen
   import uart_pkg::*;
#(
   parameter int unsigned CLKS_PER_US = 10
) (
   input  logic clk,
   input  logic arst_n,
   output logic tick
);

   us_cnt_t div_cnt;

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         div_cnt <= '0;
         tick    <= 1'b0;
      end
      else begin
         // Wrap at the end of the microsecond, pulse on the same edge
         tick <= (div_cnt == us_cnt_t'(CLKS_PER_US - 1));
         if (div_cnt == us_cnt_t'(CLKS_PER_US - 1)) begin
            div_cnt <= '0;
         end
         else begin
            div_cnt <= div_cnt + us_cnt_t'(1);
         end
      end
   end

endmodule

// ==== source/byte_fifo_if.sv ====
//----------------------------------------------------------------------
// Byte FIFO link: push side, pop side and the FIFO itself
//----------------------------------------------------------------------

`timescale 1ns/100ps

interface byte_fifo_if
   import uart_pkg::*;
();

   // Push side
   byte_t wdata;
   logic  push;
   logic  full;

   // Pop side, rdata is the head entry while empty is low
   byte_t rdata;
   logic  pop;
   logic  empty;

   modport writer (output wdata, output push, input full);

   modport reader (output pop, input rdata, input empty);

   modport fifo (
      input  wdata,
      input  push,
      input  pop,
      output full,
      output rdata,
      output empty
   );

endinterface

// ==== source/uart_pkg.sv ====
//----------------------------------------------------------------------
// UART shared definitions: data widths, bit states, bit wait tables
// and register map of the Wishbone slave
//----------------------------------------------------------------------

package uart_pkg;

   // Serial byte and microsecond wait counter
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  us_cnt_t;

   // Wishbone data and word address
   typedef logic [31:0] wb_data_t;
   typedef logic [1:0]  wb_adr_t;

   // Bit position within a frame, data bits keep their own index
   typedef enum logic [3:0] {
      D0    = 4'd0,
      D1    = 4'd1,
      D2    = 4'd2,
      D3    = 4'd3,
      D4    = 4'd4,
      D5    = 4'd5,
      D6    = 4'd6,
      D7    = 4'd7,
      STOP  = 4'd8,
      IDLE  = 4'd14,
      START = 4'd15
   } uart_bit_state_t;

   // Rx reloads, D0 to STOP, each waits reload plus one tick
   localparam us_cnt_t RX_WAIT [9] = '{4'd13, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8, 4'd7, 4'd8};

   // Tx reloads, START to STOP; START gets one extra tick for the sync
   localparam us_cnt_t TX_WAIT [10] = '{4'd9, 4'd7, 4'd8, 4'd8, 4'd7,
                                        4'd8, 4'd8, 4'd7, 4'd8, 4'd8};

   // Register map
   localparam wb_adr_t REG_DATA   = 2'd0;
   localparam wb_adr_t REG_STATUS = 2'd1;

   // Status word bits
   localparam int STAT_RX_VALID = 0;
   localparam int STAT_RX_OFLOW = 1;
   localparam int STAT_TX_BUSY  = 2;

endpackage
